// ==== source/rob_pkg.sv ====
package rob_pkg;

  // buffer geometry
  localparam int ROB_SIZE = 8;
  localparam int ROB_IX_W = 3;
  // load buffer slots checked each cycle
  localparam int LB_DEPTH = 3;

  // index into the entry arrays
  typedef logic [ROB_IX_W-1:0] rob_ix_t;
  // occupancy, one bit wider so a full buffer reads 8
  typedef logic [ROB_IX_W:0] rob_cnt_t;
  // values, addresses and pcs
  typedef logic [31:0] word_t;
  // instruction class tag
  typedef logic [3:0] itype_t;

  // instruction classes as tagged at issue
  localparam itype_t IT_OP = 4'd0;
  localparam itype_t IT_OPIMM = 4'd1;
  localparam itype_t IT_LUI = 4'd2;
  localparam itype_t IT_JAL = 4'd3;
  localparam itype_t IT_JALR = 4'd4;
  localparam itype_t IT_LOAD = 4'd5;
  // store: dest holds the base until the cdb adds the offset
  localparam itype_t IT_STORE = 4'd6;
  // branch: value bit 0 is the prediction, dest the other-path pc
  localparam itype_t IT_BRANCH = 4'd7;
  localparam itype_t IT_MUL = 4'd8;
  localparam itype_t IT_DIV = 4'd9;

  // control fsm
  // flush lasts exactly one cycle after a mispredict
  typedef enum logic {
    ST_RUN,
    ST_FLUSH
  } rob_state_t;

endpackage

// ==== source/rob_entry_if.sv ====
`timescale 1ns/1ps

interface rob_entry_if import rob_pkg::*; ();

  // from the control block
  // write the issued instruction at tail_ix this edge
  logic issue_en;
  rob_ix_t tail_ix;
  rob_ix_t head_ix;
  // one bit per occupied slot
  logic [ROB_SIZE-1:0] live_mask;
  // high during the single flush cycle
  logic flush_en;

  // from the entry arrays, every slot
  itype_t entry_type [ROB_SIZE];
  word_t entry_dest [ROB_SIZE];
  logic [ROB_SIZE-1:0] entry_ready;
  // head slot, for the commit decision
  itype_t head_type;
  logic head_ready;

  modport ctrl_mp (
    output issue_en, tail_ix, head_ix, live_mask, flush_en,
    input head_type, head_ready
  );

  modport store_mp (
    input issue_en, tail_ix, head_ix, live_mask, flush_en,
    output entry_type, entry_dest, entry_ready, head_type, head_ready
  );

  // read-only view for the load check and flush blocks
  modport view_mp (
    input issue_en, tail_ix, head_ix, live_mask, flush_en,
    input entry_type, entry_dest, entry_ready, head_type, head_ready
  );

endinterface

// ==== source/rob_ctrl.sv ====
`timescale 1ns/1ps

module rob_ctrl import rob_pkg::*; (
  input logic clk_in,
  input logic rst_in,
  input logic valid_in,
  input logic store_read_in,
  input logic mispredict,
  input rob_ix_t branch_ix,
  rob_entry_if.ctrl_mp ent,
  output logic ready_out,
  output logic commit_out,
  output logic store_valid_out,
  output rob_ix_t inst_rob_ix_out
);

  rob_ix_t head_q;
  rob_ix_t tail_q;
  rob_cnt_t count_q;
  rob_state_t state_q;
  rob_state_t state_d;
  logic running;
  logic head_live;
  logic issue;
  logic pop;
  rob_ix_t br_age;
  logic [ROB_SIZE-1:0] live;

  assign running = (state_q == ST_RUN);
  assign head_live = (count_q != '0);

  // no room when full, and nothing enters during the flush cycle
  assign ready_out = running && (count_q != rob_cnt_t'(ROB_SIZE));
  assign issue = valid_in && ready_out;

  // commit and store hand-off both wait out the flush cycle
  assign commit_out = running && head_live && ent.head_ready &&
                      (ent.head_type != IT_STORE);
  assign store_valid_out = running && head_live && ent.head_ready &&
                           (ent.head_type == IT_STORE);
  // store leaves only once memory has taken it
  assign pop = commit_out || (store_valid_out && store_read_in);

  // new instruction gets the current tail
  assign inst_rob_ix_out = tail_q;

  // distance of the branch from the head, in program order
  assign br_age = branch_ix - head_q;

  // slot is live when its age from head is below the count
  always_comb begin
    rob_ix_t age;
    age = '0;
    for (int i = 0; i < ROB_SIZE; i++) begin
      age = rob_ix_t'(i) - head_q;
      live[i] = ({1'b0, age} < count_q);
    end
  end

  assign ent.issue_en = issue;
  assign ent.tail_ix = tail_q;
  assign ent.head_ix = head_q;
  assign ent.live_mask = live;
  assign ent.flush_en = !running;

  // run/flush fsm
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_RUN: if (mispredict) state_d = ST_FLUSH;
      ST_FLUSH: state_d = ST_RUN;
      default: state_d = ST_RUN;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      head_q <= '0;
      tail_q <= '0;
      count_q <= '0;
      state_q <= ST_RUN;
    end else begin
      state_q <= state_d;
      if (pop) begin
        head_q <= head_q + 3'd1;
      end
      if (mispredict) begin
        // keep the branch, drop everything issued after it
        tail_q <= branch_ix + 3'd1;
        count_q <= {1'b0, br_age} + 4'd1 - rob_cnt_t'(pop);
      end else begin
        if (issue) begin
          tail_q <= tail_q + 3'd1;
        end
        count_q <= count_q + rob_cnt_t'(issue) - rob_cnt_t'(pop);
      end
    end
  end

endmodule

// ==== source/rob_entry_store.sv ====
`timescale 1ns/1ps

module rob_entry_store import rob_pkg::*; (
  input logic clk_in,
  input logic rst_in,
  input itype_t itype_in,
  input word_t value_in,
  input word_t dest_in,
  input logic cdb_valid_in,
  input rob_ix_t cdb_rob_ix_in,
  input word_t cdb_value_in,
  input word_t cdb_dest_in,
  input rob_ix_t decode_rob1_ix_in,
  input rob_ix_t decode_rob2_ix_in,
  rob_entry_if.store_mp ent,
  output logic mispredict,
  output rob_ix_t branch_ix,
  output word_t decode_value1_out,
  output logic decode_ready1_out,
  output word_t decode_value2_out,
  output logic decode_ready2_out,
  output rob_ix_t ix_out,
  output itype_t itype_out,
  output word_t value_out,
  output word_t dest_out,
  output logic valid_branch_out,
  output word_t alt_pc
);

  // entry payload
  itype_t type_q [ROB_SIZE];
  word_t value_q [ROB_SIZE];
  word_t dest_q [ROB_SIZE];
  // result present
  logic [ROB_SIZE-1:0] ready_q;
  logic branch_hit;

  // payload arrays
  always_ff @(posedge clk_in) begin
    if (ent.issue_en) begin
      type_q[ent.tail_ix] <= itype_in;
      value_q[ent.tail_ix] <= value_in;
      dest_q[ent.tail_ix] <= dest_in;
    end
    if (cdb_valid_in) begin
      // branch keeps its prediction bit for later comparison
      if (type_q[cdb_rob_ix_in] != IT_BRANCH) begin
        value_q[cdb_rob_ix_in] <= cdb_value_in;
      end
      // store address = issued base + offset from the cdb
      if (type_q[cdb_rob_ix_in] == IT_STORE) begin
        dest_q[cdb_rob_ix_in] <= dest_q[cdb_rob_ix_in] + cdb_dest_in;
      end
    end
  end

  // ready bits
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      ready_q <= '0;
    end else begin
      if (ent.issue_en) begin
        ready_q[ent.tail_ix] <= 1'b0;
      end
      if (cdb_valid_in) begin
        ready_q[cdb_rob_ix_in] <= 1'b1;
      end
    end
  end

  // branch result arriving on the cdb
  assign branch_hit = cdb_valid_in && ent.live_mask[cdb_rob_ix_in] &&
                      (type_q[cdb_rob_ix_in] == IT_BRANCH);
  assign valid_branch_out = branch_hit;
  // outcome differs from prediction
  // a second one inside the flush cycle is ignored
  assign mispredict = branch_hit && !ent.flush_en &&
                      (value_q[cdb_rob_ix_in][0] != cdb_value_in[0]);
  assign branch_ix = cdb_rob_ix_in;
  assign alt_pc = dest_q[cdb_rob_ix_in];

  // operand lookups, stored state only
  assign decode_value1_out = value_q[decode_rob1_ix_in];
  assign decode_ready1_out = ready_q[decode_rob1_ix_in];
  assign decode_value2_out = value_q[decode_rob2_ix_in];
  assign decode_ready2_out = ready_q[decode_rob2_ix_in];

  // head readout for commit
  assign ix_out = ent.head_ix;
  assign itype_out = type_q[ent.head_ix];
  assign value_out = value_q[ent.head_ix];
  assign dest_out = dest_q[ent.head_ix];

  // views for the other blocks
  assign ent.entry_type = type_q;
  assign ent.entry_dest = dest_q;
  assign ent.entry_ready = ready_q;
  assign ent.head_type = type_q[ent.head_ix];
  assign ent.head_ready = ready_q[ent.head_ix];

endmodule

// ==== source/rob_load_check.sv ====
`timescale 1ns/1ps

module rob_load_check import rob_pkg::*; (
  rob_entry_if.view_mp ent,
  input rob_ix_t lb_rob_ix_in [LB_DEPTH],
  input word_t lb_addr_in [LB_DEPTH],
  output logic [LB_DEPTH-1:0] can_load_out
);

  // per slot: walk the live entries older than the load
  // ages are taken relative to the head so wrap is harmless
  always_comb begin
    rob_ix_t ld_age;
    rob_ix_t st_age;
    logic is_store;
    ld_age = '0;
    st_age = '0;
    is_store = 1'b0;
    for (int i = 0; i < LB_DEPTH; i++) begin
      can_load_out[i] = 1'b1;
      ld_age = lb_rob_ix_in[i] - ent.head_ix;
      for (int j = 0; j < ROB_SIZE; j++) begin
        st_age = rob_ix_t'(j) - ent.head_ix;
        is_store = ent.live_mask[j] && (ent.entry_type[j] == IT_STORE);
        // strictly older only
        if (is_store && (st_age < ld_age)) begin
          // address unknown yet, have to wait
          if (!ent.entry_ready[j]) begin
            can_load_out[i] = 1'b0;
          end
          // same word as the load
          if (ent.entry_dest[j] == lb_addr_in[i]) begin
            can_load_out[i] = 1'b0;
          end
        end
      end
    end
  end

endmodule

// ==== source/rob_flush_unit.sv ====
`timescale 1ns/1ps

module rob_flush_unit import rob_pkg::*; (
  input logic clk_in,
  input logic rst_in,
  input logic mispredict,
  input rob_ix_t branch_ix,
  input word_t alt_pc,
  rob_entry_if.view_mp ent,
  output logic flush_out,
  output logic [4:0] flush_addrs_out [ROB_SIZE],
  output word_t next_pc_out
);

  logic [ROB_SIZE-1:0] drop;

  // classes that write a destination register
  function automatic logic writes_reg(input itype_t t);
    case (t)
      IT_OP, IT_OPIMM, IT_LUI, IT_JAL, IT_JALR, IT_LOAD, IT_MUL, IT_DIV:
        writes_reg = 1'b1;
      default:
        writes_reg = 1'b0;
    endcase
  endfunction

  // live entries issued after the branch
  always_comb begin
    rob_ix_t br_age;
    rob_ix_t age;
    br_age = branch_ix - ent.head_ix;
    age = '0;
    for (int j = 0; j < ROB_SIZE; j++) begin
      age = rob_ix_t'(j) - ent.head_ix;
      drop[j] = ent.live_mask[j] && (age > br_age) && writes_reg(ent.entry_type[j]);
    end
  end

  // one-cycle pulse, zero otherwise
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      flush_out <= 1'b0;
      next_pc_out <= '0;
      for (int j = 0; j < ROB_SIZE; j++) begin
        flush_addrs_out[j] <= '0;
      end
    end else begin
      flush_out <= mispredict;
      next_pc_out <= mispredict ? alt_pc : '0;
      for (int j = 0; j < ROB_SIZE; j++) begin
        // register number sits in the low bits of dest
        flush_addrs_out[j] <= (mispredict && drop[j]) ? ent.entry_dest[j][4:0] : 5'd0;
      end
    end
  end

endmodule

// ==== source/rob_top.sv ====
`timescale 1ns/1ps

module rob_top import rob_pkg::*; (
  input logic clk_in,
  input logic rst_in,
  // issue
  input logic valid_in,
  input itype_t itype_in,
  input word_t value_in,
  input word_t dest_in,
  output logic ready_out,
  output rob_ix_t inst_rob_ix_out,
  // common data bus
  input logic cdb_valid_in,
  input rob_ix_t cdb_rob_ix_in,
  input word_t cdb_value_in,
  input word_t cdb_dest_in,
  // decode operand lookup
  input rob_ix_t decode_rob1_ix_in,
  input rob_ix_t decode_rob2_ix_in,
  output word_t decode_value1_out,
  output logic decode_ready1_out,
  output word_t decode_value2_out,
  output logic decode_ready2_out,
  // load buffer
  input rob_ix_t lb_rob_ix_in [LB_DEPTH],
  input word_t lb_addr_in [LB_DEPTH],
  output logic [LB_DEPTH-1:0] can_load_out,
  // commit and store
  input logic store_read_in,
  output rob_ix_t ix_out,
  output itype_t itype_out,
  output word_t value_out,
  output word_t dest_out,
  output logic commit_out,
  output logic store_valid_out,
  // branch and flush
  output logic flush_out,
  output logic [4:0] flush_addrs_out [ROB_SIZE],
  output word_t next_pc_out,
  output logic valid_branch_out
);

  logic mispredict;
  rob_ix_t branch_ix;
  word_t alt_pc;

  rob_entry_if ent ();

  rob_ctrl u_ctrl (
    .clk_in, .rst_in, .valid_in, .store_read_in, .mispredict, .branch_ix,
    .ent(ent.ctrl_mp), .ready_out, .commit_out, .store_valid_out, .inst_rob_ix_out
  );

  rob_entry_store u_store (
    .clk_in, .rst_in, .itype_in, .value_in, .dest_in,
    .cdb_valid_in, .cdb_rob_ix_in, .cdb_value_in, .cdb_dest_in,
    .decode_rob1_ix_in, .decode_rob2_ix_in, .ent(ent.store_mp),
    .mispredict, .branch_ix,
    .decode_value1_out, .decode_ready1_out, .decode_value2_out, .decode_ready2_out,
    .ix_out, .itype_out, .value_out, .dest_out, .valid_branch_out, .alt_pc
  );

  rob_load_check u_load (
    .ent(ent.view_mp), .lb_rob_ix_in, .lb_addr_in, .can_load_out
  );

  rob_flush_unit u_flush (
    .clk_in, .rst_in, .mispredict, .branch_ix, .alt_pc,
    .ent(ent.view_mp), .flush_out, .flush_addrs_out, .next_pc_out
  );

endmodule

// ==== bench/rob_assert.sv ====
`timescale 1ns/1ps

module rob_assert import rob_pkg::*; (
  input logic clk_in,
  input logic rst_in,
  input logic commit_out,
  input logic store_valid_out,
  input logic ready_out,
  input logic mispredict,
  input rob_cnt_t count
);

  // one kind of retirement per cycle
  a_one_retire: assert property (@(posedge clk_in) disable iff (rst_in)
    !(commit_out && store_valid_out))
    else $error("commit and store hand-off high in the same cycle");

  // full buffer refuses issue
  a_full_stall: assert property (@(posedge clk_in) disable iff (rst_in)
    (count == rob_cnt_t'(ROB_SIZE)) |-> !ready_out)
    else $error("ready_out high with all entries live");

  a_count_range: assert property (@(posedge clk_in) disable iff (rst_in)
    count <= rob_cnt_t'(ROB_SIZE))
    else $error("occupancy above buffer size");

  // flush_out is mispredict one cycle late
  // so back to back mispredicts would stretch the flush
  a_flush_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
    mispredict |=> !mispredict)
    else $error("mispredict in two consecutive cycles");

endmodule

bind rob_ctrl rob_assert u_assert (
  .clk_in(clk_in),
  .rst_in(rst_in),
  .commit_out(commit_out),
  .store_valid_out(store_valid_out),
  .ready_out(ready_out),
  .mispredict(mispredict),
  .count(count_q)
);

// ==== bench/rob_tb.sv ====
`timescale 1ns/1ps

module rob_tb import rob_pkg::*; ();

  // traffic cycles per test, drain allowance after each
  localparam int T_ORDER = 120;
  localparam int T_FULL = 20;
  localparam int T_LOOKUP = 60;
  localparam int T_STORE = 120;
  localparam int T_LOAD = 100;
  localparam int T_BRANCH = 160;
  localparam int T_DRAIN = 60;
  localparam int CYCLE_LIMIT =
    4 * (T_ORDER + T_FULL + T_LOOKUP + T_STORE + T_LOAD + T_BRANCH + 6 * T_DRAIN);

  logic clk_in = 1'b0;
  logic rst_in;
  logic valid_in;
  itype_t itype_in;
  word_t value_in;
  word_t dest_in;
  logic ready_out;
  rob_ix_t inst_rob_ix_out;
  logic cdb_valid_in;
  rob_ix_t cdb_rob_ix_in;
  word_t cdb_value_in;
  word_t cdb_dest_in;
  rob_ix_t decode_rob1_ix_in;
  rob_ix_t decode_rob2_ix_in;
  word_t decode_value1_out;
  logic decode_ready1_out;
  word_t decode_value2_out;
  logic decode_ready2_out;
  rob_ix_t lb_rob_ix_in [LB_DEPTH];
  word_t lb_addr_in [LB_DEPTH];
  logic [LB_DEPTH-1:0] can_load_out;
  logic store_read_in;
  rob_ix_t ix_out;
  itype_t itype_out;
  word_t value_out;
  word_t dest_out;
  logic commit_out;
  logic store_valid_out;
  logic flush_out;
  logic [4:0] flush_addrs_out [ROB_SIZE];
  word_t next_pc_out;
  logic valid_branch_out;

  // reference model of the buffer
  itype_t m_type [ROB_SIZE];
  word_t m_val [ROB_SIZE];
  word_t m_dest [ROB_SIZE];
  logic [ROB_SIZE-1:0] m_rdy;
  rob_ix_t m_head;
  rob_ix_t m_tail;
  int m_cnt;
  logic m_flush;
  // registered flush outputs due this cycle
  logic e_flush;
  word_t e_npc;
  logic [4:0] e_faddr [ROB_SIZE];

  logic [31:0] lfsr;
  int cycles = 0;
  int n_checks = 0;
  int n_errors = 0;
  int n_issued = 0;
  int n_mispredicts = 0;
  int test_err0 = 0;
  int start;

  rob_top dut (.*);

  always #20 clk_in = ~clk_in;

  // hard stop if a test never drains
  always @(posedge clk_in) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("sim failed");
      $finish;
    end
  end

  // galois form, right shift
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return r;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // age in program order, head is 0
  function automatic rob_ix_t age_of(input rob_ix_t ix);
    return ix - m_head;
  endfunction

  function automatic logic is_live(input rob_ix_t ix);
    return int'(age_of(ix)) < m_cnt;
  endfunction

  function automatic logic writes_register(input itype_t t);
    case (t)
      IT_OP, IT_OPIMM, IT_LUI, IT_JAL, IT_JALR, IT_LOAD, IT_MUL, IT_DIV: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // blocked by an older store that is unresolved or hits the same address
  function automatic logic load_allowed(input int i);
    logic ok;
    ok = 1'b1;
    for (int j = 0; j < ROB_SIZE; j++) begin
      if (is_live(j) && m_type[j] == IT_STORE && age_of(j) < age_of(lb_rob_ix_in[i]) &&
          (!m_rdy[j] || m_dest[j] == lb_addr_in[i])) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  task automatic reset_model();
    m_head = '0;
    m_tail = '0;
    m_cnt = 0;
    m_flush = 1'b0;
    m_rdy = '0;
    e_flush = 1'b0;
    e_npc = '0;
    for (int j = 0; j < ROB_SIZE; j++) begin
      m_type[j] = '0;
      m_val[j] = '0;
      m_dest[j] = '0;
      e_faddr[j] = '0;
    end
  endtask

  // compare every output against the model, mid cycle
  task automatic check_outputs();
    logic head_done;
    logic exp_commit;
    logic exp_store;
    logic exp_vb;
    rob_ix_t h;
    h = m_head;
    head_done = !m_flush && (m_cnt != 0) && m_rdy[h];
    exp_commit = head_done && (m_type[h] != IT_STORE);
    exp_store = head_done && (m_type[h] == IT_STORE);
    // issues the dut takes at the coming edge
    if (valid_in && ready_out) begin
      n_issued++;
    end
    check_val("ready_out", ready_out, !m_flush && (m_cnt != ROB_SIZE));
    check_val("inst_rob_ix_out", inst_rob_ix_out, m_tail);
    check_val("commit_out", commit_out, exp_commit);
    check_val("store_valid_out", store_valid_out, exp_store);
    // head readout only matters when it retires
    if (exp_commit || exp_store) begin
      check_val("ix_out", ix_out, h);
      check_val("itype_out", itype_out, m_type[h]);
      check_val("value_out", value_out, m_val[h]);
      check_val("dest_out", dest_out, m_dest[h]);
    end
    if (is_live(decode_rob1_ix_in)) begin
      check_val("decode_value1_out", decode_value1_out, m_val[decode_rob1_ix_in]);
      check_val("decode_ready1_out", decode_ready1_out, m_rdy[decode_rob1_ix_in]);
    end
    if (is_live(decode_rob2_ix_in)) begin
      check_val("decode_value2_out", decode_value2_out, m_val[decode_rob2_ix_in]);
      check_val("decode_ready2_out", decode_ready2_out, m_rdy[decode_rob2_ix_in]);
    end
    exp_vb = cdb_valid_in && is_live(cdb_rob_ix_in) && (m_type[cdb_rob_ix_in] == IT_BRANCH);
    check_val("valid_branch_out", valid_branch_out, exp_vb);
    for (int i = 0; i < LB_DEPTH; i++) begin
      check_val($sformatf("can_load_out[%0d]", i), can_load_out[i], load_allowed(i));
    end
    check_val("flush_out", flush_out, e_flush);
    check_val("next_pc_out", next_pc_out, e_npc);
    for (int j = 0; j < ROB_SIZE; j++) begin
      check_val($sformatf("flush_addrs_out[%0d]", j), flush_addrs_out[j], e_faddr[j]);
    end
  endtask

  // advance the model over one rising edge, inputs as sampled there
  task automatic update_model();
    logic issue;
    logic pop;
    logic mis;
    rob_ix_t bix;
    issue = valid_in && !m_flush && (m_cnt != ROB_SIZE);
    pop = !m_flush && (m_cnt != 0) && m_rdy[m_head] &&
          (m_type[m_head] != IT_STORE || store_read_in);
    bix = cdb_rob_ix_in;
    mis = cdb_valid_in && !m_flush && is_live(bix) && (m_type[bix] == IT_BRANCH) &&
          (m_val[bix][0] != cdb_value_in[0]);
    // flush outputs come from the state before this edge
    e_flush = mis;
    e_npc = mis ? m_dest[bix] : '0;
    for (int j = 0; j < ROB_SIZE; j++) begin
      e_faddr[j] = (mis && is_live(j) && age_of(j) > age_of(bix) && writes_register(m_type[j]))
                   ? m_dest[j][4:0] : 5'd0;
    end
    if (cdb_valid_in) begin
      if (m_type[bix] != IT_BRANCH) begin
        m_val[bix] = cdb_value_in;
      end
      // store offset lands on the base
      if (m_type[bix] == IT_STORE) begin
        m_dest[bix] = m_dest[bix] + cdb_dest_in;
      end
      m_rdy[bix] = 1'b1;
    end
    if (issue) begin
      m_type[m_tail] = itype_in;
      m_val[m_tail] = value_in;
      m_dest[m_tail] = dest_in;
      m_rdy[m_tail] = 1'b0;
    end
    if (mis) begin
      // branch stays, younger entries go
      m_cnt = int'(age_of(bix)) + 1 - int'(pop);
      m_tail = bix + 3'd1;
      n_mispredicts++;
    end else begin
      m_tail = m_tail + rob_ix_t'(issue);
      m_cnt = m_cnt + int'(issue) - int'(pop);
    end
    m_head = m_head + rob_ix_t'(pop);
    m_flush = mis;
  endtask

  task automatic tick();
    @(negedge clk_in);
    check_outputs();
    @(posedge clk_in);
    update_model();
  endtask

  function automatic itype_t pick_type(input logic allow_store, input logic allow_branch);
    itype_t regs [8];
    regs = '{IT_OP, IT_OPIMM, IT_LUI, IT_JAL, IT_JALR, IT_LOAD, IT_MUL, IT_DIV};
    if (allow_store && rand_bits(2) == 0) begin
      return IT_STORE;
    end
    if (allow_branch && rand_bits(2) == 0) begin
      return IT_BRANCH;
    end
    return regs[rand_bits(3)];
  endfunction

  // random live entry still waiting for its result, -1 if none
  function automatic int pick_pending();
    rob_ix_t ix;
    int found;
    ix = rob_ix_t'(rand_bits(3));
    found = -1;
    for (int k = 0; k < ROB_SIZE; k++) begin
      if (found < 0 && is_live(ix) && !m_rdy[ix]) begin
        found = int'(ix);
      end
      ix = ix + 3'd1;
    end
    return found;
  endfunction

  // next cycle's inputs, applied at this edge
  task automatic drive_cycle(input logic issue_on, input logic cdb_on,
                             input logic allow_store, input logic allow_branch);
    itype_t t;
    int p;
    t = pick_type(allow_store, allow_branch);
    p = pick_pending();
    valid_in <= issue_on && (rand_bits(2) != 0);
    itype_in <= t;
    if (t == IT_BRANCH) begin
      // prediction bit, then the other-path pc
      value_in <= rand_bits(1);
      dest_in <= rand_bits(32);
    end else if (t == IT_STORE) begin
      // small bases so loads alias now and then
      value_in <= rand_bits(32);
      dest_in <= rand_bits(4);
    end else begin
      value_in <= rand_bits(32);
      dest_in <= rand_bits(8);
    end
    // no cdb traffic in the flush cycle
    cdb_valid_in <= cdb_on && !m_flush && (p >= 0) && rand_bits(1);
    cdb_rob_ix_in <= (p >= 0) ? rob_ix_t'(p) : rob_ix_t'(0);
    cdb_value_in <= rand_bits(32);
    cdb_dest_in <= rand_bits(2);
    store_read_in <= (rand_bits(2) == 0);
    decode_rob1_ix_in <= rob_ix_t'(rand_bits(3));
    decode_rob2_ix_in <= rob_ix_t'(rand_bits(3));
    for (int i = 0; i < LB_DEPTH; i++) begin
      lb_rob_ix_in[i] <= rob_ix_t'(rand_bits(3));
      lb_addr_in[i] <= rand_bits(4);
    end
  endtask

  task automatic run_traffic(input int n, input logic allow_store, input logic allow_branch);
    repeat (n) begin
      tick();
      drive_cycle(1'b1, 1'b1, allow_store, allow_branch);
    end
  endtask

  // no issue, finish everything in flight
  task automatic drain();
    while (m_cnt != 0 || m_flush) begin
      tick();
      drive_cycle(1'b0, 1'b1, 1'b0, 1'b0);
    end
  endtask

  task automatic finish_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, n_errors - test_err0);
    test_err0 = n_errors;
  endtask

  initial begin
    rst_in = 1'b1;
    valid_in = 1'b0;
    itype_in = IT_OP;
    value_in = '0;
    dest_in = '0;
    cdb_valid_in = 1'b0;
    cdb_rob_ix_in = '0;
    cdb_value_in = '0;
    cdb_dest_in = '0;
    decode_rob1_ix_in = '0;
    decode_rob2_ix_in = '0;
    store_read_in = 1'b0;
    for (int i = 0; i < LB_DEPTH; i++) begin
      lb_rob_ix_in[i] = '0;
      lb_addr_in[i] = '0;
    end
    lfsr = 32'hd002;
    repeat (3) @(posedge clk_in);
    rst_in <= 1'b0;
    reset_model();

    run_traffic(T_ORDER, 1'b0, 1'b0);
    drain();
    finish_test(1, "in-order commit");

    // fill with no completions, then free one slot
    start = n_issued;
    repeat (T_FULL - 8) begin
      tick();
      drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
      valid_in <= 1'b1;
    end
    check_val("issues accepted by a full buffer", n_issued - start, 8);
    tick();
    drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    valid_in <= 1'b1;
    cdb_valid_in <= 1'b1;
    cdb_rob_ix_in <= m_head;
    // result, commit, then the waiting issue
    repeat (4) begin
      tick();
      drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
      valid_in <= 1'b1;
    end
    check_val("issues accepted after one commit", n_issued - start, 9);
    drain();
    finish_test(2, "full and back-pressure");

    run_traffic(T_LOOKUP, 1'b0, 1'b0);
    drain();
    finish_test(3, "operand lookup");

    run_traffic(T_STORE, 1'b1, 1'b0);
    drain();
    finish_test(4, "store hand-off");

    run_traffic(T_LOAD, 1'b1, 1'b0);
    drain();
    finish_test(5, "load disambiguation");

    start = n_mispredicts;
    run_traffic(T_BRANCH, 1'b1, 1'b1);
    drain();
    if (n_mispredicts == start) begin
      $display("branch test never produced a mispredicted branch");
      n_errors++;
    end
    finish_test(6, "branches");

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
source/rob_pkg.sv
source/rob_entry_if.sv
source/rob_ctrl.sv
source/rob_entry_store.sv
source/rob_load_check.sv
source/rob_flush_unit.sv
source/rob_top.sv
bench/rob_assert.sv
bench/rob_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the reorder buffer testbench with verilator
# fails on a broken step or when the log reports failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module rob_tb -f flist.f -o rob_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/rob_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
exit 0
